/* core_pkg.sv */
`default_nettype none

package core_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;

	typedef enum logic [3:0] {
		op_none,
		op_lb,
		op_lh,
		op_lw,
		op_lbu,
		op_lhu,
		op_sb,
		op_sh,
		op_sw
	} mem_op_e;

	typedef enum logic [1:0] {
		wb_alu,
		wb_mem,
		wb_pc4
	} wb_sel_e;

	typedef struct packed {
		logic      valid;
		word_t     pc;
		word_t     alu_out;   // also the word address of a load or store.
		word_t     rs2_data;
		mem_op_e   mem_op;
		logic      rf_wen;
		wb_sel_e   wb_sel;
		reg_addr_t wb_addr;
	} ex_mem_t;

	typedef struct packed {
		logic      valid;
		word_t     pc;
		word_t     alu_out;
		word_t     read_data;
		logic      rf_wen;
		wb_sel_e   wb_sel;
		reg_addr_t wb_addr;
	} mem_wb_t;

endpackage

`default_nettype wire

/* mem_bus_pkg.sv */
`default_nettype none

package mem_bus_pkg;

	typedef enum logic [1:0] {
		cmd_nop,
		cmd_read,
		cmd_write
	} mem_cmd_e;

	typedef logic [3:0] byte_mask_t;

	typedef struct packed {
		mem_cmd_e        cmd;
		core_pkg::word_t addr;
		core_pkg::word_t wdata;
		byte_mask_t      wmask;   // lane 0 is bits 7:0.
	} mem_req_t;

endpackage

`default_nettype wire

/* mem_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_stage (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire core_pkg::ex_mem_t ex_in,
	output logic                   stall,
	output core_pkg::mem_wb_t      mem_out,
	output mem_bus_pkg::mem_req_t  mem_req,
	input  wire                    cmd_ready,
	input  wire core_pkg::word_t   rdata,
	input  wire                    rdata_valid
);

	typedef enum logic [1:0] {
		st_wait,
		st_wait_ready,
		st_wait_valid,
		st_end
	} state_e;

	state_e            state;
	core_pkg::ex_mem_t held;        // instruction in flight.
	core_pkg::word_t   load_data;
	logic              held_store;
	logic              ex_mem_op;

	function automatic core_pkg::word_t extend_load(input core_pkg::mem_op_e op,
			input core_pkg::word_t data);
		case (op)
			core_pkg::op_lb:  extend_load = {{24{data[7]}}, data[7:0]};
			core_pkg::op_lbu: extend_load = {24'b0, data[7:0]};
			core_pkg::op_lh:  extend_load = {{16{data[15]}}, data[15:0]};
			core_pkg::op_lhu: extend_load = {16'b0, data[15:0]};
			default:          extend_load = data;
		endcase
	endfunction

	function automatic mem_bus_pkg::byte_mask_t store_mask(input core_pkg::mem_op_e op);
		case (op)
			core_pkg::op_sb: store_mask = 4'b0001;
			core_pkg::op_sh: store_mask = 4'b0011;
			core_pkg::op_sw: store_mask = 4'b1111;
			default:         store_mask = 4'b0000;
		endcase
	endfunction

	function automatic core_pkg::mem_wb_t pass_down(input core_pkg::ex_mem_t ex,
			input core_pkg::word_t read_data);
		pass_down = '{
			valid:     ex.valid,
			pc:        ex.pc,
			alu_out:   ex.alu_out,
			read_data: read_data,
			rf_wen:    ex.rf_wen,
			wb_sel:    ex.wb_sel,
			wb_addr:   ex.wb_addr
		};
	endfunction

	assign ex_mem_op  = ex_in.valid && (ex_in.mem_op != core_pkg::op_none);
	assign held_store = held.mem_op inside {core_pkg::op_sb, core_pkg::op_sh, core_pkg::op_sw};

	always_comb begin
		case (state)
			st_wait: stall = ex_mem_op;
			st_end:  stall = 1'b0;   // source moves on from here.
			default: stall = 1'b1;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state         <= st_wait;
			mem_req.cmd   <= mem_bus_pkg::cmd_nop;
			mem_out.valid <= 1'b0;
		end else begin
			mem_out.valid <= 1'b0;
			case (state)
				st_wait: begin
					mem_out       <= pass_down(ex_in, '1);
					mem_out.valid <= ex_in.valid && !ex_mem_op;
					if (ex_mem_op) begin
						state <= st_wait_ready;
					end
				end
				st_wait_ready: begin
					if (mem_req.cmd != mem_bus_pkg::cmd_nop) begin   // on the bus this cycle.
						mem_req.cmd <= mem_bus_pkg::cmd_nop;
						state       <= held_store ? st_end : st_wait_valid;
					end else if (cmd_ready) begin
						mem_req.cmd   <= held_store ? mem_bus_pkg::cmd_write
							: mem_bus_pkg::cmd_read;
						mem_req.addr  <= held.alu_out;
						mem_req.wdata <= held.rs2_data;
						mem_req.wmask <= store_mask(held.mem_op);
					end
				end
				st_wait_valid: begin
					if (rdata_valid) begin
						state <= st_end;
					end
				end
				st_end: begin
					mem_out <= pass_down(held, held_store ? '1 : load_data);
					state   <= st_wait;
				end
				default: state <= st_wait;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_wait && ex_mem_op) begin
			held <= ex_in;
		end
		if (state == st_wait_valid && rdata_valid) begin
			load_data <= extend_load(held.mem_op, rdata);
		end
	end

	a_cmd_ready: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req.cmd != mem_bus_pkg::cmd_nop |-> cmd_ready)
		else $error("mem_stage: command issued while the RAM is busy.");

	a_hold: assert property (@(posedge clk) disable iff (!rst_n)
		stall |=> $stable(ex_in))
		else $error("mem_stage: ex_in changed during stall.");

	a_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
		rdata_valid |-> state == st_wait_valid)
		else $error("mem_stage: unexpected rdata_valid.");

endmodule

`default_nettype wire

/* data_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module data_ram #(
	parameter int ADDR_W       = 8,
	parameter int READ_LATENCY = 2
) (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire mem_bus_pkg::mem_req_t mem_req,
	output logic                       cmd_ready,
	output core_pkg::word_t            rdata,
	output logic                       rdata_valid
);

	localparam int CNT_W = $clog2(READ_LATENCY + 1);

	typedef logic [ADDR_W-1:0] ram_addr_t;
	typedef logic [CNT_W-1:0]  lat_cnt_t;

	core_pkg::word_t mem [2**ADDR_W];
	ram_addr_t       idx;
	lat_cnt_t        lat_cnt;
	logic            busy;
	logic            take_read;
	logic            take_write;

	assign idx         = mem_req.addr[ADDR_W-1:0];   // upper bits of the word address are ignored.
	assign cmd_ready   = !busy;
	assign take_read   = cmd_ready && (mem_req.cmd == mem_bus_pkg::cmd_read);
	assign take_write  = cmd_ready && (mem_req.cmd == mem_bus_pkg::cmd_write);
	assign rdata_valid = busy && (lat_cnt == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			lat_cnt <= '0;
		end else if (take_read) begin
			busy    <= 1'b1;
			lat_cnt <= lat_cnt_t'(READ_LATENCY - 1);
		end else if (busy) begin
			if (lat_cnt == '0) begin
				busy <= 1'b0;   // ready again after the pulse.
			end else begin
				lat_cnt <= lat_cnt - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take_write) begin
			for (int i = 0; i < 4; i++) begin
				if (mem_req.wmask[i]) begin
					mem[idx][8*i +: 8] <= mem_req.wdata[8*i +: 8];
				end
			end
		end
		if (take_read) begin
			rdata <= mem[idx];   // no write can land while busy.
		end
	end

	a_latency: assert property (@(posedge clk) READ_LATENCY >= 1)
		else $error("data_ram: READ_LATENCY must be at least 1.");

endmodule

`default_nettype wire

/* writeback_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module writeback_stage (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire core_pkg::mem_wb_t mem_out,
	output logic                   rf_we,
	output core_pkg::reg_addr_t    rf_waddr,
	output core_pkg::word_t        rf_wdata
);

	core_pkg::word_t wb_value;

	always_comb begin
		case (mem_out.wb_sel)
			core_pkg::wb_mem: wb_value = mem_out.read_data;
			core_pkg::wb_pc4: wb_value = mem_out.pc + 32'd4;
			default:          wb_value = mem_out.alu_out;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rf_we <= 1'b0;
		end else begin
			rf_we <= mem_out.valid && mem_out.rf_wen && (mem_out.wb_addr != '0);   // x0 stays zero.
		end
	end

	always_ff @(posedge clk) begin
		if (mem_out.valid) begin
			rf_waddr <= mem_out.wb_addr;
			rf_wdata <= wb_value;
		end
	end

endmodule

`default_nettype wire

/* mem_wb_top.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_wb_top #(
	parameter int ADDR_W       = 8,
	parameter int READ_LATENCY = 2
) (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire core_pkg::ex_mem_t ex_in,
	output logic                   stall,
	output logic                   rf_we,
	output core_pkg::reg_addr_t    rf_waddr,
	output core_pkg::word_t        rf_wdata
);

	mem_bus_pkg::mem_req_t mem_req;
	logic                  cmd_ready;
	core_pkg::word_t       rdata;
	logic                  rdata_valid;
	core_pkg::mem_wb_t     mem_out;

	mem_stage i_mem_stage (
		.clk         (clk),
		.rst_n       (rst_n),
		.ex_in       (ex_in),
		.stall       (stall),
		.mem_out     (mem_out),
		.mem_req     (mem_req),
		.cmd_ready   (cmd_ready),
		.rdata       (rdata),
		.rdata_valid (rdata_valid)
	);

	data_ram #(
		.ADDR_W       (ADDR_W),
		.READ_LATENCY (READ_LATENCY)
	) i_data_ram (
		.clk         (clk),
		.rst_n       (rst_n),
		.mem_req     (mem_req),
		.cmd_ready   (cmd_ready),
		.rdata       (rdata),
		.rdata_valid (rdata_valid)
	);

	writeback_stage i_writeback_stage (
		.clk      (clk),
		.rst_n    (rst_n),
		.mem_out  (mem_out),
		.rf_we    (rf_we),
		.rf_waddr (rf_waddr),
		.rf_wdata (rf_wdata)
	);

endmodule

`default_nettype wire

/* tb_mem_wb.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_mem_wb;

	localparam int ADDR_W       = 6;
	localparam int READ_LATENCY = 2;
	localparam int NUM_WORDS    = 2**ADDR_W;
	localparam int NUM_INSTR    = 300;
	localparam int MAX_CYCLES   = (NUM_WORDS + NUM_INSTR) * 10 + 100;
	localparam logic [31:0] SEED = 32'h6b1066da;

	typedef struct packed {
		core_pkg::reg_addr_t waddr;
		core_pkg::word_t     wdata;
		logic [31:0]         due;     // cycle count when rf_we is sampled high.
	} rf_write_t;

	logic                clk;
	logic                rst_n;
	core_pkg::ex_mem_t   ex_in;
	logic                stall;
	logic                rf_we;
	core_pkg::reg_addr_t rf_waddr;
	core_pkg::word_t     rf_wdata;

	core_pkg::word_t     mem_model [NUM_WORDS];
	rf_write_t           exp_q [$];
	int                  errors = 0;
	int                  cycle = 0;

	mem_wb_top #(
		.ADDR_W       (ADDR_W),
		.READ_LATENCY (READ_LATENCY)
	) i_dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.ex_in    (ex_in),
		.stall    (stall),
		.rf_we    (rf_we),
		.rf_waddr (rf_waddr),
		.rf_wdata (rf_wdata)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	function automatic core_pkg::ex_mem_t fill_store(input int addr);
		core_pkg::ex_mem_t instr;
		instr          = '0;
		instr.valid    = 1'b1;
		instr.pc       = addr * 4;
		instr.alu_out  = addr;
		instr.rs2_data = $urandom;
		instr.mem_op   = core_pkg::op_sw;
		instr.wb_sel   = core_pkg::wb_alu;
		return instr;
	endfunction

	function automatic core_pkg::ex_mem_t random_instr();
		core_pkg::ex_mem_t instr;
		instr.valid    = 1'b1;
		instr.pc       = $urandom & ~32'h3;
		instr.mem_op   = core_pkg::mem_op_e'($urandom % 9);
		instr.rs2_data = $urandom;
		instr.rf_wen   = ($urandom % 4) != 0;
		instr.wb_sel   = core_pkg::wb_sel_e'($urandom % 3);
		instr.wb_addr  = core_pkg::reg_addr_t'($urandom % 32);
		if (instr.mem_op == core_pkg::op_none) begin
			instr.alu_out = $urandom;
		end else begin
			instr.alu_out = ($urandom % 2) ? $urandom % 8 : $urandom % NUM_WORDS;   // few hot words.
		end
		if (instr.mem_op inside {core_pkg::op_lb, core_pkg::op_lh, core_pkg::op_lw,
				core_pkg::op_lbu, core_pkg::op_lhu} && ($urandom % 4) != 0) begin
			instr.wb_sel = core_pkg::wb_mem;
		end
		return instr;
	endfunction

	// updates the memory model and queues the expected register write.
	task automatic accept_instr(input core_pkg::ex_mem_t instr, input int stalled);
		logic [ADDR_W-1:0] idx;
		core_pkg::word_t   word;
		core_pkg::word_t   read_data;
		core_pkg::word_t   value;
		int                exp_stall;
		idx       = instr.alu_out[ADDR_W-1:0];
		word      = mem_model[idx];
		read_data = '1;
		exp_stall = 0;
		case (instr.mem_op)
			core_pkg::op_lb: read_data = {{24{word[7]}}, word[7:0]};
			core_pkg::op_lbu: read_data = {24'b0, word[7:0]};
			core_pkg::op_lh: read_data = {{16{word[15]}}, word[15:0]};
			core_pkg::op_lhu: read_data = {16'b0, word[15:0]};
			core_pkg::op_lw: read_data = word;
			core_pkg::op_sb: mem_model[idx][7:0] = instr.rs2_data[7:0];
			core_pkg::op_sh: mem_model[idx][15:0] = instr.rs2_data[15:0];
			core_pkg::op_sw: mem_model[idx] = instr.rs2_data;
			default: ;
		endcase
		if (instr.mem_op inside {core_pkg::op_sb, core_pkg::op_sh, core_pkg::op_sw}) begin
			exp_stall = 3;
		end else if (instr.mem_op != core_pkg::op_none) begin
			exp_stall = 3 + READ_LATENCY;   // the read waits out the RAM latency.
		end
		if (stalled != exp_stall) begin
			errors++;
			$display("FAILED stall cycles: got %h expected %h (op %s)", stalled, exp_stall,
				instr.mem_op.name());
		end
		case (instr.wb_sel)
			core_pkg::wb_mem: value = read_data;
			core_pkg::wb_pc4: value = instr.pc + 32'd4;
			default:          value = instr.alu_out;
		endcase
		if (instr.rf_wen && instr.wb_addr != 0) begin
			exp_q.push_back('{waddr: instr.wb_addr, wdata: value, due: cycle + 2});
		end
	endtask

	// holds the instruction until stall is seen low at a clock edge.
	task automatic send_instr(input core_pkg::ex_mem_t instr);
		int stalled;
		stalled = 0;
		ex_in <= instr;
		@(posedge clk);
		while (stall) begin
			stalled++;
			@(posedge clk);
		end
		accept_instr(instr, stalled);
	endtask

	task automatic idle_cycles(input int n);
		ex_in <= '0;
		repeat (n) @(posedge clk);
	endtask

	always @(posedge clk) begin
		rf_write_t exp;
		if (rst_n && rf_we) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("register write to x%0d with no instruction expecting it", rf_waddr);
			end else begin
				exp = exp_q.pop_front();
				if (rf_waddr !== exp.waddr) begin
					errors++;
					$display("FAILED rf_waddr: got %h expected %h", rf_waddr, exp.waddr);
				end
				if (rf_wdata !== exp.wdata) begin
					errors++;
					$display("FAILED rf_wdata: got %h expected %h", rf_wdata, exp.wdata);
				end
				if (cycle != exp.due) begin
					errors++;
					$display("FAILED rf_we cycle: got %h expected %h", cycle, exp.due);
				end
			end
		end
	end

	initial begin
		while (cycle < MAX_CYCLES) @(posedge clk);
		$display("timeout after %0d cycles, %0d errors so far", cycle, errors);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		int gap;
		void'($urandom(SEED));
		rst_n = 1'b0;
		ex_in = '0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		for (int i = 0; i < NUM_WORDS; i++) begin
			send_instr(fill_store(i));   // every word gets a known value.
		end
		for (int i = 0; i < NUM_INSTR; i++) begin
			gap = (($urandom % 4) == 0) ? ($urandom % 3) + 1 : 0;
			if (gap > 0) begin
				idle_cycles(gap);
			end
			send_instr(random_instr());
		end
		idle_cycles(4);
		if (exp_q.size() != 0) begin
			errors++;
			$display("%0d register writes never appeared", exp_q.size());
		end
		$display("run finished after %0d cycles with %0d errors", cycle, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
core_pkg.sv
mem_bus_pkg.sv
mem_stage.sv
data_ram.sv
writeback_stage.sv
mem_wb_top.sv
tb_mem_wb.sv
